//--- Bender.yml
package:
  name: aud_capture

sources:
  - hdl/aud_pkg.sv
  - hdl/mem_pkg.sv
  - hdl/sample_stream_if.sv
  - hdl/aud_recorder.sv
  - hdl/sample_fifo.sv
  - hdl/sram_writer.sv
  - hdl/aud_capture_top.sv
  - target: simulation
    files:
      - sim/wb_mem_model.sv
      - sim/tb_aud_capture.sv

//--- hdl/aud_capture_top.sv
module aud_capture_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_lrc,
    input  logic                        i_data,
    input  logic                        i_start,
    input  logic                        i_pause,
    input  logic                        i_stop,
    output logic                        o_recording,
    output logic                        o_overrun,
    output logic                        o_done,
    output logic                        o_wb_cyc,
    output logic                        o_wb_stb,
    output logic                        o_wb_we,
    output logic [mem_pkg::ADDR_W-1:0]  o_wb_adr,
    output logic [mem_pkg::DATA_W-1:0]  o_wb_dat,
    input  logic                        i_wb_ack
);

    sample_stream_if rec_stream ();
    sample_stream_if mem_stream ();

    aud_recorder u_recorder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_lrc       (i_lrc),
        .i_data      (i_data),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .o_recording (o_recording),
        .o_overrun   (o_overrun),
        .rec_stream  (rec_stream.src)
    );

    // The buffer rides out slow acknowledges from the memory.
    sample_fifo u_fifo (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .rec_stream (rec_stream.snk),
        .mem_stream (mem_stream.src)
    );

    sram_writer u_writer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .mem_stream (mem_stream.snk),
        .o_wb_cyc   (o_wb_cyc),
        .o_wb_stb   (o_wb_stb),
        .o_wb_we    (o_wb_we),
        .o_wb_adr   (o_wb_adr),
        .o_wb_dat   (o_wb_dat),
        .i_wb_ack   (i_wb_ack),
        .o_done     (o_done)
    );

endmodule

//--- hdl/aud_pkg.sv
package aud_pkg;

    // ########################################
    // Sample format
    // ########################################

    localparam int SAMPLE_W  = 16;
    localparam int BIT_CNT_W = $clog2(SAMPLE_W);

    // Index of the final bit of a sample in the bit counter.
    localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(SAMPLE_W - 1);

    // Kept small so a full recording fits in a short simulation.
    localparam int REC_LIMIT = 64;
    localparam int REC_CNT_W = $clog2(REC_LIMIT);
    localparam logic [REC_CNT_W-1:0] LAST_IDX = REC_CNT_W'(REC_LIMIT - 1);

    // ########################################
    // Sample buffer
    // ########################################

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;
    localparam logic [FIFO_CNT_W-1:0] FIFO_FULL = FIFO_CNT_W'(FIFO_DEPTH);

    // Recorder FSM states.
    typedef enum logic [2:0] {
        REC_IDLE,
        REC_WAIT,
        REC_SHIFT,
        REC_HOLD,
        REC_FINISH
    } rec_state_e;

endpackage

//--- hdl/aud_recorder.sv
module aud_recorder (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_lrc,
    input  logic               i_data,
    input  logic               i_start,
    input  logic               i_pause,
    input  logic               i_stop,
    output logic               o_recording,
    output logic               o_overrun,
    sample_stream_if.src       rec_stream
);

    aud_pkg::rec_state_e                state_r, state_w;
    logic [aud_pkg::SAMPLE_W-1:0]      data_r, data_w;
    logic [aud_pkg::BIT_CNT_W-1:0]     bit_cnt_r, bit_cnt_w;
    logic [aud_pkg::REC_CNT_W-1:0]     rec_cnt_r, rec_cnt_w;
    logic                              stop_r, stop_w;
    logic                              ovr_r, ovr_w;
    logic                              lrc_q;
    logic                              frame_start;
    logic                              recording;
    logic                              sample_last;

    // A frame starts on the first edge where LRC is low after being high.
    assign frame_start = lrc_q & ~i_lrc;

    assign recording   = (state_r != aud_pkg::REC_IDLE) && (state_r != aud_pkg::REC_FINISH);
    assign sample_last = stop_r || (rec_cnt_r == aud_pkg::LAST_IDX);

    assign rec_stream.valid = (state_r == aud_pkg::REC_HOLD);
    assign rec_stream.data  = data_r;
    assign rec_stream.last  = sample_last;

    assign o_recording = recording;
    assign o_overrun   = ovr_r;

    // ########################################
    // Capture FSM
    // ########################################

    always_comb begin
        state_w   = state_r;
        data_w    = data_r;
        bit_cnt_w = bit_cnt_r;
        rec_cnt_w = rec_cnt_r;
        stop_w    = stop_r;
        ovr_w     = ovr_r;
        case (state_r)
            aud_pkg::REC_IDLE: begin
                if (i_start) begin
                    state_w   = aud_pkg::REC_WAIT;
                    rec_cnt_w = '0;
                    stop_w    = 1'b0;
                    ovr_w     = 1'b0;
                end
            end
            aud_pkg::REC_WAIT: begin
                // A frame that starts with pause high is skipped entirely.
                if (frame_start && !i_pause) begin
                    data_w    = {data_r[aud_pkg::SAMPLE_W-2:0], i_data};
                    bit_cnt_w = 1'b1;
                    state_w   = aud_pkg::REC_SHIFT;
                end
            end
            aud_pkg::REC_SHIFT: begin
                data_w    = {data_r[aud_pkg::SAMPLE_W-2:0], i_data};
                bit_cnt_w = bit_cnt_r + 1'b1;
                if (bit_cnt_r == aud_pkg::LAST_BIT) begin
                    state_w = aud_pkg::REC_HOLD;
                end
            end
            aud_pkg::REC_HOLD: begin
                if (rec_stream.ready) begin
                    rec_cnt_w = rec_cnt_r + 1'b1;
                    state_w   = sample_last ? aud_pkg::REC_FINISH : aud_pkg::REC_WAIT;
                end else begin
                    // The buffer is full, so this sample is lost.
                    ovr_w   = 1'b1;
                    state_w = aud_pkg::REC_WAIT;
                end
            end
            aud_pkg::REC_FINISH: begin
                stop_w  = 1'b0;
                state_w = aud_pkg::REC_IDLE;
            end
            default: begin
                state_w = aud_pkg::REC_IDLE;
            end
        endcase
        // Stop is latched whenever it arrives during a recording.
        if (i_stop && recording) begin
            stop_w = 1'b1;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r   <= aud_pkg::REC_IDLE;
            bit_cnt_r <= '0;
            rec_cnt_r <= '0;
            stop_r    <= 1'b0;
            ovr_r     <= 1'b0;
            lrc_q     <= 1'b0;
        end else begin
            state_r   <= state_w;
            bit_cnt_r <= bit_cnt_w;
            rec_cnt_r <= rec_cnt_w;
            stop_r    <= stop_w;
            ovr_r     <= ovr_w;
            lrc_q     <= i_lrc;
        end
    end

    always_ff @(posedge i_clk) begin
        data_r <= data_w;
    end

endmodule

//--- hdl/mem_pkg.sv
package mem_pkg;

    // ########################################
    // Sample memory format
    // ########################################

    // Word address into the sample memory.
    localparam int ADDR_W = 20;

    // One memory word holds one sample.
    localparam int DATA_W = 16;

    // Writer FSM states.
    // WR_BUS covers the whole Wishbone cycle up to and including ack.
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_BUS,
        WR_DONE
    } wr_state_e;

endpackage

//--- hdl/sample_fifo.sv
module sample_fifo (
    input  logic           i_clk,
    input  logic           i_rst_n,
    sample_stream_if.snk   rec_stream,
    sample_stream_if.src   mem_stream
);

    logic [aud_pkg::SAMPLE_W-1:0]   data_mem [aud_pkg::FIFO_DEPTH];
    logic                           last_mem [aud_pkg::FIFO_DEPTH];
    logic [aud_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [aud_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [aud_pkg::FIFO_CNT_W-1:0] count;
    logic                           push;
    logic                           pop;

    assign rec_stream.ready = (count != aud_pkg::FIFO_FULL);
    assign mem_stream.valid = (count != '0);

    // Reading straight from the array makes a push visible one cycle later.
    assign mem_stream.data  = data_mem[rd_ptr];
    assign mem_stream.last  = last_mem[rd_ptr];

    assign push = rec_stream.valid & rec_stream.ready;
    assign pop  = mem_stream.valid & mem_stream.ready;

    // ########################################
    // Pointers and occupancy
    // ########################################

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            data_mem[wr_ptr] <= rec_stream.data;
            last_mem[wr_ptr] <= rec_stream.last;
        end
    end

endmodule

//--- hdl/sample_stream_if.sv
interface sample_stream_if;

    logic                          valid;
    logic                          ready;
    logic [aud_pkg::SAMPLE_W-1:0]  data;
    // Marks the final sample of a recording.
    logic                          last;

    modport src (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport snk (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

//--- hdl/sram_writer.sv
module sram_writer (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    sample_stream_if.snk                mem_stream,
    output logic                        o_wb_cyc,
    output logic                        o_wb_stb,
    output logic                        o_wb_we,
    output logic [mem_pkg::ADDR_W-1:0]  o_wb_adr,
    output logic [mem_pkg::DATA_W-1:0]  o_wb_dat,
    input  logic                        i_wb_ack,
    output logic                        o_done
);

    mem_pkg::wr_state_e                state_r, state_w;
    logic [mem_pkg::ADDR_W-1:0]        adr_r, adr_w;
    logic [mem_pkg::DATA_W-1:0]        dat_r;
    logic                              last_r;
    logic                              accept;

    // One sample is taken only while no bus cycle is pending.
    assign mem_stream.ready = (state_r == mem_pkg::WR_IDLE);
    assign accept           = mem_stream.valid & mem_stream.ready;

    assign o_wb_cyc = (state_r == mem_pkg::WR_BUS);
    assign o_wb_stb = (state_r == mem_pkg::WR_BUS);
    assign o_wb_we  = (state_r == mem_pkg::WR_BUS);
    assign o_wb_adr = adr_r;
    assign o_wb_dat = dat_r;
    assign o_done   = (state_r == mem_pkg::WR_DONE);

    // ########################################
    // Write FSM
    // ########################################

    always_comb begin
        state_w = state_r;
        adr_w   = adr_r;
        case (state_r)
            mem_pkg::WR_IDLE: begin
                if (accept) begin
                    state_w = mem_pkg::WR_BUS;
                end
            end
            mem_pkg::WR_BUS: begin
                if (i_wb_ack) begin
                    if (last_r) begin
                        state_w = mem_pkg::WR_DONE;
                    end else begin
                        adr_w   = adr_r + 1'b1;
                        state_w = mem_pkg::WR_IDLE;
                    end
                end
            end
            mem_pkg::WR_DONE: begin
                // The next recording starts again at word zero.
                adr_w   = '0;
                state_w = mem_pkg::WR_IDLE;
            end
            default: begin
                state_w = mem_pkg::WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r <= mem_pkg::WR_IDLE;
            adr_r   <= '0;
        end else begin
            state_r <= state_w;
            adr_r   <= adr_w;
        end
    end

    // Data stays steady for the whole bus cycle.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            dat_r  <= mem_stream.data;
            last_r <= mem_stream.last;
        end
    end

endmodule

//--- sim/aud_capture_tests.txt
# Columns: name, ack delay in cycles (0 = random), action, k, p, overrun expected,
# frames sent, samples listed, then the listed samples in hex.
# Samples beyond the listed ones count up by one from the last listed sample.
# Actions: plain and pause stop before the final frame, stop requests a stop
# after k frames, pause skips frames k to k+p-1, limit sends no stop at all.
#
# Plain recordings.
plain      1  plain  0 0 0   8  8  1234 8001 7fff 0000 ffff a5a5 5a5a 0f0f
short      2  plain  0 0 0   2  2  dead beef
random     0  plain  0 0 0  12 12  0101 0202 0404 0808 1010 2020 4040 8080 1111 3333 7777 ffff
#
# Pauses over whole frames.
pause      3  pause  3 2 0  10 10  1111 2222 3333 4444 5555 6666 7777 8888 9999 aaaa
pause_long 0  pause  1 4 0   8  8  2001 2002 2003 2004 2005 2006 2007 2008
#
# Stop requests with frames still arriving afterwards.
stop       2  stop   4 0 0  10 10  c001 c002 c003 c004 c005 c006 c007 c008 c009 c00a
stop_early 1  stop   1 0 0   6  6  e100 e200 e300 e400 e500 e600
#
# Runs past the sample limit.
limit      2  limit  0 0 0  70  1  4000
limit_rnd  0  limit  0 0 0  66  1  b000
#
# Slow memory fills the buffer and drops samples.
flood    150  stop  16 0 1  26  1  6000
#
# A new start after the overrun clears the flag and writes from word zero.
restart    1  plain  0 0 0   6  6  9a01 9a02 9a03 9a04 9a05 9a06

//--- sim/tb_aud_capture.sv
module tb_aud_capture;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_TESTS  = 16;
    localparam int MAX_FRAMES = 80;
    localparam int DONE_WAIT  = 4000;

    logic i_clk, i_rst_n, i_lrc, i_data, i_start, i_pause, i_stop, i_wb_ack;
    logic o_recording, o_overrun, o_done, o_wb_cyc, o_wb_stb, o_wb_we;
    logic [mem_pkg::ADDR_W-1:0]   o_wb_adr;
    logic [mem_pkg::DATA_W-1:0]   o_wb_dat;
    logic [15:0]                  ack_delay;

    logic [8*16-1:0]              t_name [MAX_TESTS];
    logic [8*8-1:0]               t_act [MAX_TESTS];
    int                           t_delay [MAX_TESTS];
    int                           t_k [MAX_TESTS];
    int                           t_p [MAX_TESTS];
    int                           t_ovr [MAX_TESTS];
    int                           t_frames [MAX_TESTS];
    logic [aud_pkg::SAMPLE_W-1:0] t_smp [MAX_TESTS][MAX_FRAMES];
    int n_tests = 0;
    int total_frames = 0;
    int done_count = 0;
    int n_pass = 0;
    int n_fail = 0;
    int wd_cycles = 0;
    int seed;

    aud_capture_top u_dut (.*);

    wb_mem_model u_mem (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (o_wb_cyc),
        .i_wb_stb    (o_wb_stb),
        .i_wb_we     (o_wb_we),
        .i_wb_adr    (o_wb_adr),
        .i_wb_dat    (o_wb_dat),
        .i_ack_delay (ack_delay),
        .o_wb_ack    (i_wb_ack)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(negedge i_clk) begin
        if (o_done === 1'b1) begin
            done_count <= done_count + 1;
        end
    end

    // ########################################
    // Test file and serial frames
    // ########################################

    task automatic read_tests();
        int fd, code, i, listed;
        logic [8*16-1:0]  tok;
        logic [8*128-1:0] rest;
        fd = $fopen("sim/aud_capture_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test file sim/aud_capture_tests.txt");
            n_fail++;
        end else begin
            while (n_tests < MAX_TESTS && $fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    t_name[n_tests] = tok;
                    code = $fscanf(fd, "%d %s %d %d %d %d %d", t_delay[n_tests],
                                   t_act[n_tests], t_k[n_tests], t_p[n_tests],
                                   t_ovr[n_tests], t_frames[n_tests], listed);
                    // Unlisted samples count up from the previous one.
                    for (i = 0; i < t_frames[n_tests]; i++) begin
                        if (i < listed) begin
                            code = $fscanf(fd, "%h", t_smp[n_tests][i]);
                        end else begin
                            t_smp[n_tests][i] = t_smp[n_tests][i-1] + 1'b1;
                        end
                    end
                    total_frames += t_frames[n_tests];
                    n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Left word carries the sample MSB first, the right word is zero.
    // Control requests change in the right half, away from any frame start.
    task automatic send_frames(input int t, input int stop_f, input int p_on, input int p_off);
        int f, b;
        for (f = 0; f < t_frames[t]; f++) begin
            for (b = 0; b < 32; b++) begin
                @(posedge i_clk);
                #1;
                i_lrc  = (b >= 16);
                i_data = (b < 16) ? t_smp[t][f][aud_pkg::SAMPLE_W-1-b] : 1'b0;
                i_stop = (b == 20) && (f == stop_f);
                if (b == 20 && f == p_on) begin
                    i_pause = 1'b1;
                end else if (b == 20 && f == p_off) begin
                    i_pause = 1'b0;
                end
            end
        end
    endtask

    task automatic run_test(input int t);
        int stop_f, p_on, p_off, base_wr, base_done, n, i, j, exp_n, errs;
        logic [aud_pkg::SAMPLE_W-1:0] exp_w [MAX_FRAMES];
        stop_f = (t_act[t] == "stop") ? t_k[t] - 1 : t_frames[t] - 2;
        stop_f = (t_act[t] == "limit") ? -1 : stop_f;
        p_on   = (t_act[t] == "pause") ? t_k[t] - 1 : -1;
        p_off  = (t_act[t] == "pause") ? t_k[t] + t_p[t] - 1 : -1;
        exp_n  = 0;
        for (i = 0; i < t_frames[t]; i++) begin
            if (!((t_act[t] == "pause" && i >= t_k[t] && i < t_k[t] + t_p[t])
                  || (t_act[t] == "stop" && i > t_k[t])
                  || (t_act[t] == "limit" && i >= aud_pkg::REC_LIMIT))) begin
                exp_w[exp_n] = t_smp[t][i];
                exp_n++;
            end
        end
        errs      = 0;
        ack_delay = 16'(t_delay[t]);
        base_wr   = u_mem.wr_count;
        base_done = done_count;
        @(posedge i_clk);
        #1;
        i_start = 1'b1;
        @(posedge i_clk);
        #1;
        i_start = 1'b0;
        if (o_overrun !== 1'b0) begin
            $display("FAIL o_overrun after start expected 0 actual %h", o_overrun);
            errs++;
        end
        if (o_recording !== 1'b1) begin
            $display("FAIL o_recording after start expected 1 actual %h", o_recording);
            errs++;
        end
        send_frames(t, stop_f, p_on, p_off);
        n = 0;
        while (done_count == base_done && n < DONE_WAIT) begin
            @(posedge i_clk);
            n++;
        end
        if (done_count == base_done) begin
            $display("no o_done pulse within %0d cycles after the last frame", DONE_WAIT);
            errs++;
        end
        repeat (64) @(posedge i_clk);
        #1;
        if (done_count - base_done != 1) begin
            $display("FAIL o_done pulses expected 1 actual %h", done_count - base_done);
            errs++;
        end
        if (o_recording !== 1'b0) begin
            $display("FAIL o_recording expected 0 actual %h", o_recording);
            errs++;
        end
        if (o_overrun !== t_ovr[t][0]) begin
            $display("FAIL o_overrun expected %h actual %h", t_ovr[t][0], o_overrun);
            errs++;
        end
        n = u_mem.wr_count - base_wr;
        if (t_ovr[t] == 0) begin
            if (n != exp_n) begin
                $display("FAIL write count expected %h actual %h", exp_n, n);
                errs++;
            end
            for (i = 0; i < exp_n; i++) begin
                if (u_mem.mem[i] !== exp_w[i]) begin
                    $display("FAIL mem[%0d] expected %h actual %h", i, exp_w[i], u_mem.mem[i]);
                    errs++;
                end
            end
        end else begin
            if (n == 0 || n >= t_frames[t]) begin
                $display("stored %0d words, but fewer than the %0d sent were expected",
                         n, t_frames[t]);
                errs++;
            end
            j = 0;
            for (i = 0; i < n; i++) begin
                while (j < t_frames[t] && t_smp[t][j] !== u_mem.mem[i]) begin
                    j++;
                end
                if (j == t_frames[t]) begin
                    $display("memory word %0d is out of order or was never sent", i);
                    errs++;
                    break;
                end
                j++;
            end
        end
        if (errs == 0) begin
            $display("[%0s] passed", t_name[t]);
            n_pass++;
        end else begin
            $display("[%0s] failed with %0d errors", t_name[t], errs);
            n_fail++;
        end
    endtask

    // ########################################
    // Main sequence
    // ########################################

    initial begin
        seed      = $urandom(32'hc0bbe4ee);
        i_rst_n   = 1'b1;
        i_lrc     = 1'b1;
        i_data    = 1'b0;
        i_start   = 1'b0;
        i_pause   = 1'b0;
        i_stop    = 1'b0;
        ack_delay = 16'd1;
        read_tests();
        wd_cycles = total_frames * 32 * 4;
        repeat (5) @(posedge i_clk);
        #1;
        if ({o_wb_cyc, o_wb_stb, o_wb_we, o_recording, o_overrun, o_done} !== 6'b0) begin
            $display("FAIL o_wb_cyc/stb/we/o_recording/o_overrun/o_done expected 00 actual %h",
                     {o_wb_cyc, o_wb_stb, o_wb_we, o_recording, o_overrun, o_done});
            n_fail++;
        end
        i_rst_n = 1'b0;
        repeat (4) @(posedge i_clk);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        wait (wd_cycles > 0);
        #(wd_cycles * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the tests finished", wd_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- sim/wb_mem_model.sv
module wb_mem_model (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  logic [mem_pkg::ADDR_W-1:0]  i_wb_adr,
    input  logic [mem_pkg::DATA_W-1:0]  i_wb_dat,
    input  logic [15:0]                 i_ack_delay,
    output logic                        o_wb_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [mem_pkg::DATA_W-1:0] mem [256];
    int   wr_count = 0;
    int   wait_cnt;
    logic busy;

    // A delay of zero draws a fresh random wait for every bus cycle.
    function automatic int pick_delay(input logic [15:0] delay);
        int d;
        if (delay == 16'd0) begin
            d = $urandom % 8;
        end else begin
            d = delay;
        end
        return d;
    endfunction

    always @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            o_wb_ack <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 0;
        end else begin
            o_wb_ack <= 1'b0;
            if (i_wb_cyc && i_wb_stb && !o_wb_ack) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    wait_cnt <= pick_delay(i_ack_delay);
                end else if (wait_cnt == 0) begin
                    busy     <= 1'b0;
                    o_wb_ack <= 1'b1;
                    if (i_wb_we) begin
                        mem[i_wb_adr[7:0]] <= i_wb_dat;
                        wr_count           <= wr_count + 1;
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

//--- vlog.f
hdl/aud_pkg.sv
hdl/mem_pkg.sv
hdl/sample_stream_if.sv
hdl/aud_recorder.sv
hdl/sample_fifo.sv
hdl/sram_writer.sv
hdl/aud_capture_top.sv
sim/wb_mem_model.sv
sim/tb_aud_capture.sv
